// File: hw/blit_data_pkg.sv
// Phrase format is fixed at 64 bits in eight bytes, with byte 0 in bits 7..0 of every phrase
`default_nettype none

package blit_data_pkg;

	localparam int PHRASE_W = 64;
	localparam int BYTES = 8;
	localparam int BYTE_W = PHRASE_W / BYTES;
	localparam int SHIFT_W = 3;

	typedef logic [PHRASE_W-1:0] phrase_t;
	typedef logic [BYTES-1:0] byte_mask_t;

	// Minterm enables, bit 3 = S&D, bit 2 = S&~D, bit 1 = ~S&D, bit 0 = ~S&~D
	typedef logic [3:0] lfu_func_t;

	typedef enum logic [1:0] {
		SEL_LFU = 2'd0,
		SEL_PAT = 2'd1,
		SEL_DST = 2'd2,
		SEL_SRC = 2'd3
	} data_sel_e;

	typedef struct packed {
		lfu_func_t lfu_func;
		data_sel_e data_sel;
		logic cmp_dst;
		logic [SHIFT_W-1:0] shift;
		byte_mask_t inhibit;    // Set bit keeps the destination byte
	} blit_ctrl_t;

	typedef struct packed {
		phrase_t srcd1;
		phrase_t srcd2;
		phrase_t dstd;
		phrase_t patd;
	} blit_phrases_t;

endpackage

`default_nettype wire

// File: hw/blit_bus_pkg.sv
// Wishbone classic only, 32-bit data and word addressing, no byte selects and no bursts
`default_nettype none

package blit_bus_pkg;

	localparam int WB_DW = 32;
	localparam int WB_AW = 3;

	// Bit positions of the fields in the CTRL word
	localparam int CTRL_LFU_LSB = 0;
	localparam int CTRL_LFU_MSB = 3;
	localparam int CTRL_SEL_LSB = 4;
	localparam int CTRL_SEL_MSB = 5;
	localparam int CTRL_CMP_BIT = 6;
	localparam int CTRL_SHIFT_LSB = 8;
	localparam int CTRL_SHIFT_MSB = 10;
	localparam int CTRL_INH_LSB = 16;
	localparam int CTRL_INH_MSB = 23;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [WB_AW-1:0] adr;
		logic [WB_DW-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [WB_DW-1:0] dat;
	} wb_rsp_t;

	typedef enum logic [WB_AW-1:0] {
		REG_SRC_LO = 3'd0,
		REG_SRC_HI = 3'd1,
		REG_DST_LO = 3'd2,
		REG_DST_HI = 3'd3,
		REG_PAT_LO = 3'd4,
		REG_PAT_HI = 3'd5,
		REG_CTRL   = 3'd6
	} reg_addr_e;

endpackage

`default_nettype wire

// File: hw/blit_regs.sv
// Acks one cycle after the request and only once per strobe; address 7 acks, reads zero
`timescale 1ns/1ps
`default_nettype none

module blit_regs
	import blit_data_pkg::*;
	import blit_bus_pkg::*;
(
	input  logic          sys_clk,
	input  logic          rst,
	input  wb_req_t       wb_req,
	output wb_rsp_t       wb_rsp,
	output blit_phrases_t phrases,
	output blit_ctrl_t    ctrl
);

	logic req;
	logic stb_seen;
	logic access;
	logic ack_q;
	logic [WB_DW-1:0] rdat_q;
	logic [WB_DW-1:0] rd_word;
	logic [WB_DW-1:0] ctrl_word;
	logic [WB_DW-1:0] src1_lo;
	logic [WB_DW-1:0] src1_hi;
	logic [WB_DW-1:0] dst_lo;
	logic [WB_DW-1:0] dst_hi;
	logic [WB_DW-1:0] pat_lo;
	logic [WB_DW-1:0] pat_hi;
	phrase_t srcd2_q;
	blit_ctrl_t ctrl_q;
	reg_addr_e addr;

	assign req = wb_req.cyc & wb_req.stb;
	// First cycle of a request only, a held strobe is not served twice
	assign access = req & ~stb_seen;
	assign addr = reg_addr_e'(wb_req.adr);

	// CTRL readback, unused bits read as zero
	always_comb begin
		ctrl_word = '0;
		ctrl_word[CTRL_LFU_MSB:CTRL_LFU_LSB] = ctrl_q.lfu_func;
		ctrl_word[CTRL_SEL_MSB:CTRL_SEL_LSB] = ctrl_q.data_sel;
		ctrl_word[CTRL_CMP_BIT] = ctrl_q.cmp_dst;
		ctrl_word[CTRL_SHIFT_MSB:CTRL_SHIFT_LSB] = ctrl_q.shift;
		ctrl_word[CTRL_INH_MSB:CTRL_INH_LSB] = ctrl_q.inhibit;
	end

	always_comb begin
		case (addr)
			REG_SRC_LO: rd_word = src1_lo;
			REG_SRC_HI: rd_word = src1_hi;
			REG_DST_LO: rd_word = dst_lo;
			REG_DST_HI: rd_word = dst_hi;
			REG_PAT_LO: rd_word = pat_lo;
			REG_PAT_HI: rd_word = pat_hi;
			REG_CTRL:   rd_word = ctrl_word;
			default:    rd_word = '0;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			stb_seen <= 1'b0;
			ack_q <= 1'b0;
			rdat_q <= '0;
		end else begin
			stb_seen <= req;
			ack_q <= access;
			if (access) begin
				rdat_q <= wb_req.we ? '0 : rd_word;
			end
		end
	end

	// Register writes land on the same edge that raises ack
	always_ff @(posedge sys_clk) begin
		if (rst) begin
			src1_lo <= '0;
			src1_hi <= '0;
			srcd2_q <= '0;
			dst_lo <= '0;
			dst_hi <= '0;
			pat_lo <= '0;
			pat_hi <= '0;
			ctrl_q <= '0;
		end else if (access && wb_req.we) begin
			case (addr)
				REG_SRC_LO: begin
					// Low word write advances the source pipeline
					srcd2_q <= {src1_hi, src1_lo};
					src1_lo <= wb_req.dat;
				end
				REG_SRC_HI: src1_hi <= wb_req.dat;
				REG_DST_LO: dst_lo <= wb_req.dat;
				REG_DST_HI: dst_hi <= wb_req.dat;
				REG_PAT_LO: pat_lo <= wb_req.dat;
				REG_PAT_HI: pat_hi <= wb_req.dat;
				REG_CTRL: begin
					ctrl_q.lfu_func <= wb_req.dat[CTRL_LFU_MSB:CTRL_LFU_LSB];
					ctrl_q.data_sel <= data_sel_e'(wb_req.dat[CTRL_SEL_MSB:CTRL_SEL_LSB]);
					ctrl_q.cmp_dst <= wb_req.dat[CTRL_CMP_BIT];
					ctrl_q.shift <= wb_req.dat[CTRL_SHIFT_MSB:CTRL_SHIFT_LSB];
					ctrl_q.inhibit <= wb_req.dat[CTRL_INH_MSB:CTRL_INH_LSB];
				end
				default: ;
			endcase
		end
	end

	always_comb begin
		wb_rsp.ack = ack_q;
		wb_rsp.dat = rdat_q;
		phrases.srcd1 = {src1_hi, src1_lo};
		phrases.srcd2 = srcd2_q;
		phrases.dstd = {dst_hi, dst_lo};
		phrases.patd = {pat_hi, pat_lo};
	end

	assign ctrl = ctrl_q;

endmodule

`default_nettype wire

// File: hw/src_shift.sv
// Byte granular shift only, offsets 0 to 7 into the sixteen bytes of the two source stages
`timescale 1ns/1ps
`default_nettype none

module src_shift
	import blit_data_pkg::*;
(
	input  phrase_t            srcd1,
	input  phrase_t            srcd2,
	input  logic [SHIFT_W-1:0] shift,
	output phrase_t            srcd
);

	// Older stage in the low bytes, newer stage above it
	logic [2*PHRASE_W-1:0] window;

	assign window = {srcd1, srcd2};

	// Each output byte picks from the window at its own index plus the offset
	always_comb begin
		for (int i = 0; i < BYTES; i++) begin
			srcd[i*BYTE_W +: BYTE_W] = window[(i + int'(shift))*BYTE_W +: BYTE_W];
		end
	end

endmodule

`default_nettype wire

// File: hw/data_comp.sv
// Combinational, compares whole bytes only, one dcomp bit per byte of the phrase
`timescale 1ns/1ps
`default_nettype none

module data_comp
	import blit_data_pkg::*;
(
	input  phrase_t    patd,
	input  phrase_t    srcd,
	input  phrase_t    dstd,
	input  logic       cmp_dst,
	output byte_mask_t dcomp
);

	for (genvar i = 0; i < BYTES; i++) begin : g_byte
		logic [BYTE_W-1:0] cmp_byte;

		// Destination or aligned source as the compare operand
		assign cmp_byte = cmp_dst ? dstd[i*BYTE_W +: BYTE_W] : srcd[i*BYTE_W +: BYTE_W];
		assign dcomp[i] = (patd[i*BYTE_W +: BYTE_W] == cmp_byte);
	end

endmodule

`default_nettype wire

// File: hw/data_out.sv
// One phrase per data_ena cycle with no back-pressure; output holds while data_ena is low
`timescale 1ns/1ps
`default_nettype none

module data_out
	import blit_data_pkg::*;
(
	input  logic       sys_clk,
	input  logic       rst,
	input  blit_ctrl_t ctrl,
	input  phrase_t    srcd,
	input  phrase_t    dstd,
	input  phrase_t    patd,
	input  logic       data_ena,
	output phrase_t    wdata_out,
	output logic       wdata_oe
);

	phrase_t lfu;
	phrase_t sel;
	phrase_t merged;
	phrase_t wdata_q;
	logic oe_q;

	// Sum of the enabled minterms, bit by bit
	assign lfu = ({PHRASE_W{ctrl.lfu_func[3]}} & srcd & dstd)
	           | ({PHRASE_W{ctrl.lfu_func[2]}} & srcd & ~dstd)
	           | ({PHRASE_W{ctrl.lfu_func[1]}} & ~srcd & dstd)
	           | ({PHRASE_W{ctrl.lfu_func[0]}} & ~srcd & ~dstd);

	always_comb begin
		sel = lfu;
		case (ctrl.data_sel)
			SEL_LFU: sel = lfu;
			SEL_PAT: sel = patd;
			SEL_DST: sel = dstd;
			SEL_SRC: sel = srcd;
		endcase
	end

	// Inhibited bytes write back what is already in the destination
	always_comb begin
		for (int i = 0; i < BYTES; i++) begin
			if (ctrl.inhibit[i]) begin
				merged[i*BYTE_W +: BYTE_W] = dstd[i*BYTE_W +: BYTE_W];
			end else begin
				merged[i*BYTE_W +: BYTE_W] = sel[i*BYTE_W +: BYTE_W];
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			wdata_q <= '0;
			oe_q <= 1'b0;
		end else begin
			oe_q <= data_ena;
			if (data_ena) begin
				wdata_q <= merged;
			end
		end
	end

	assign wdata_out = wdata_q;
	assign wdata_oe = oe_q;

endmodule

`default_nettype wire

// File: hw/blit_data_path.sv
// Host loads all operands over Wishbone; the sink must take every phrase while wdata_oe is high
`timescale 1ns/1ps
`default_nettype none

module blit_data_path
	import blit_data_pkg::*;
	import blit_bus_pkg::*;
(
	input  logic       sys_clk,
	input  logic       rst,
	input  wb_req_t    wb_req,
	output wb_rsp_t    wb_rsp,
	input  logic       data_ena,
	output phrase_t    wdata_out,
	output logic       wdata_oe,
	output byte_mask_t dcomp
);

	blit_phrases_t phrases;
	blit_ctrl_t ctrl;
	phrase_t srcd;

	blit_regs blit_regs_inst (
		.sys_clk (sys_clk),
		.rst     (rst),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.phrases (phrases),
		.ctrl    (ctrl)
	);

	// Aligned source feeds both the compare and the output path
	src_shift src_shift_inst (
		.srcd1 (phrases.srcd1),
		.srcd2 (phrases.srcd2),
		.shift (ctrl.shift),
		.srcd  (srcd)
	);

	data_comp data_comp_inst (
		.patd    (phrases.patd),
		.srcd    (srcd),
		.dstd    (phrases.dstd),
		.cmp_dst (ctrl.cmp_dst),
		.dcomp   (dcomp)
	);

	data_out data_out_inst (
		.sys_clk   (sys_clk),
		.rst       (rst),
		.ctrl      (ctrl),
		.srcd      (srcd),
		.dstd      (phrases.dstd),
		.patd      (phrases.patd),
		.data_ena  (data_ena),
		.wdata_out (wdata_out),
		.wdata_oe  (wdata_oe)
	);

endmodule

`default_nettype wire

// File: verif/tb_blit_data_path.sv
// Directed testbench; expects a one-cycle Wishbone ack and drives every input 2 ns after the edge
`timescale 1ns/1ps
`default_nettype none

module tb_blit_data_path
	import blit_data_pkg::*;
	import blit_bus_pkg::*;
();

	logic sys_clk;
	logic rst;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic data_ena;
	phrase_t wdata_out;
	logic wdata_oe;
	byte_mask_t dcomp;
	logic [31:0] lcg_state;

	blit_data_path blit_data_path_inst (
		.sys_clk   (sys_clk),
		.rst       (rst),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.data_ena  (data_ena),
		.wdata_out (wdata_out),
		.wdata_oe  (wdata_oe),
		.dcomp     (dcomp)
	);

	always #20 sys_clk = ~sys_clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic phrase_t rand_phrase();
		return {lcg_next(), lcg_next()};
	endfunction

	// CTRL word with fields at bits 3..0, 5..4, 6, 10..8 and 23..16
	function automatic logic [31:0] ctrl_value(input logic [3:0] func, input data_sel_e sel,
		input logic cmp, input logic [2:0] shift, input byte_mask_t inh);
		return {8'h00, inh, 5'd0, shift, 1'b0, cmp, sel, func};
	endfunction

	task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
		assert (got === exp) else begin
			$display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	task automatic wait_ack();
		int cycles;
		cycles = 0;
		do begin
			@(posedge sys_clk);
			#2;
			cycles++;
		end while (!wb_rsp.ack && cycles < 20);
		if (!wb_rsp.ack) begin
			$display("Timeout: the Wishbone slave did not acknowledge within 20 cycles");
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
		wait_ack();
		// Strobe stays low for one edge so the next request counts as new
		wb_req = '0;
		@(posedge sys_clk);
		#2;
	endtask

	task automatic wb_read(input logic [2:0] adr, output logic [31:0] dat);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'd0};
		wait_ack();
		dat = wb_rsp.dat;
		wb_req = '0;
		@(posedge sys_clk);
		#2;
	endtask

	task automatic load_phrase(input logic [2:0] lo_adr, input phrase_t p);
		wb_write(lo_adr, p[31:0]);
		wb_write(lo_adr + 3'd1, p[63:32]);
	endtask

	// Pulses data_ena for one cycle and compares the registered phrase
	task automatic capture_check(input phrase_t exp, input string what);
		data_ena = 1'b1;
		@(posedge sys_clk);
		#2;
		data_ena = 1'b0;
		check_equal(64'(wdata_oe), 64'd1, "wdata_oe after data_ena");
		check_equal(wdata_out, exp, what);
	endtask

	task automatic reset_readback();
		logic [31:0] vals [8];
		logic [31:0] rd;
		check_equal(64'(wdata_oe), 64'd0, "wdata_oe after reset");
		check_equal(64'(wb_rsp.ack), 64'd0, "ack after reset");
		check_equal(wdata_out, 64'd0, "wdata_out after reset");
		for (int a = 0; a < 8; a++) begin
			wb_read(3'(a), rd);
			check_equal(64'(rd), 64'd0, "register after reset");
		end
		for (int a = 0; a < 8; a++) begin
			vals[a] = lcg_next();
			wb_write(3'(a), vals[a]);
		end
		// CTRL keeps only its defined fields and address 7 holds nothing
		vals[6] = vals[6] & 32'h00ff_077f;
		vals[7] = 32'd0;
		for (int a = 0; a < 8; a++) begin
			wb_read(3'(a), rd);
			check_equal(64'(rd), 64'(vals[a]), "register readback");
		end
	endtask

	task automatic logic_function();
		phrase_t s, d, exp;
		logic [3:0] func;
		s = rand_phrase();
		d = rand_phrase();
		// Loaded twice so that the shift 0 window is s
		load_phrase(REG_SRC_LO, s);
		load_phrase(REG_SRC_LO, s);
		load_phrase(REG_DST_LO, d);
		for (int f = 0; f < 16; f++) begin
			func = 4'(f);
			wb_write(REG_CTRL, ctrl_value(func, SEL_LFU, 1'b0, 3'd0, 8'h00));
			// Minterm index is {source bit, destination bit}
			for (int b = 0; b < PHRASE_W; b++) begin
				exp[b] = func[{s[b], d[b]}];
			end
			capture_check(exp, "LFU result");
		end
	endtask

	task automatic source_alignment();
		phrase_t first, second;
		logic [2*PHRASE_W-1:0] bytes16;
		first = rand_phrase();
		second = rand_phrase();
		load_phrase(REG_SRC_LO, first);
		load_phrase(REG_SRC_LO, second);
		// Older phrase in the low eight bytes
		bytes16 = {second, first};
		for (int sh = 0; sh < BYTES; sh++) begin
			wb_write(REG_CTRL, ctrl_value(4'h0, SEL_SRC, 1'b0, 3'(sh), 8'h00));
			capture_check(bytes16[sh*8 +: PHRASE_W], "aligned source");
		end
	endtask

	task automatic pattern_compare();
		phrase_t s1, s2, d, p, aligned;
		logic [2*PHRASE_W-1:0] bytes16;
		byte_mask_t exp_dst, exp_src;
		s1 = rand_phrase();
		s2 = rand_phrase();
		d = rand_phrase();
		p = rand_phrase();
		// Aligned source is the window at byte offset 3 of the two stages
		bytes16 = {s2, s1};
		aligned = bytes16[3*8 +: PHRASE_W];
		// Every third byte matches the destination and the byte after it the aligned source
		for (int i = 0; i < BYTES; i++) begin
			if (i % 3 == 0) begin
				p[i*8 +: 8] = d[i*8 +: 8];
			end else if (i % 3 == 1) begin
				p[i*8 +: 8] = aligned[i*8 +: 8];
			end
			exp_dst[i] = (p[i*8 +: 8] == d[i*8 +: 8]);
			exp_src[i] = (p[i*8 +: 8] == aligned[i*8 +: 8]);
		end
		load_phrase(REG_SRC_LO, s1);
		load_phrase(REG_SRC_LO, s2);
		load_phrase(REG_DST_LO, d);
		load_phrase(REG_PAT_LO, p);
		wb_write(REG_CTRL, ctrl_value(4'h0, SEL_LFU, 1'b1, 3'd3, 8'h00));
		check_equal(64'(dcomp), 64'(exp_dst), "dcomp against destination");
		wb_write(REG_CTRL, ctrl_value(4'h0, SEL_LFU, 1'b0, 3'd3, 8'h00));
		check_equal(64'(dcomp), 64'(exp_src), "dcomp against source");
	endtask

	task automatic select_inhibit();
		phrase_t s, d, p, chosen, exp;
		byte_mask_t inh;
		data_sel_e sel;
		s = rand_phrase();
		d = rand_phrase();
		p = rand_phrase();
		load_phrase(REG_SRC_LO, s);
		load_phrase(REG_SRC_LO, s);
		load_phrase(REG_DST_LO, d);
		load_phrase(REG_PAT_LO, p);
		for (int k = 0; k < 9; k++) begin
			// Cycles through pattern, destination and source
			sel = data_sel_e'(2'(k % 3 + 1));
			inh = 8'(lcg_next());
			chosen = (sel == SEL_PAT) ? p : (sel == SEL_DST) ? d : s;
			for (int i = 0; i < BYTES; i++) begin
				exp[i*8 +: 8] = inh[i] ? d[i*8 +: 8] : chosen[i*8 +: 8];
			end
			wb_write(REG_CTRL, ctrl_value(4'h0, sel, 1'b0, 3'd0, inh));
			capture_check(exp, "selected phrase with inhibit");
		end
	endtask

	task automatic enable_timing();
		phrase_t d;
		logic [31:0] new_lo;
		d = rand_phrase();
		new_lo = lcg_next();
		load_phrase(REG_DST_LO, d);
		wb_write(REG_CTRL, ctrl_value(4'h0, SEL_DST, 1'b0, 3'd0, 8'h00));
		check_equal(64'(wdata_oe), 64'd0, "wdata_oe before the sequence");
		data_ena = 1'b1;
		@(posedge sys_clk);
		#2;
		check_equal(64'(wdata_oe), 64'd1, "wdata_oe after first high");
		check_equal(wdata_out, d, "first phrase");
		// Destination write lands on the edge of the second capture
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: REG_DST_LO, dat: new_lo};
		@(posedge sys_clk);
		#2;
		check_equal(64'(wb_rsp.ack), 64'd1, "ack of the destination write");
		check_equal(64'(wdata_oe), 64'd1, "wdata_oe after second high");
		check_equal(wdata_out, d, "second phrase");
		wb_req = '0;
		data_ena = 1'b0;
		@(posedge sys_clk);
		#2;
		check_equal(64'(wdata_oe), 64'd0, "wdata_oe after low");
		check_equal(wdata_out, d, "phrase held through low");
		data_ena = 1'b1;
		@(posedge sys_clk);
		#2;
		data_ena = 1'b0;
		check_equal(64'(wdata_oe), 64'd1, "wdata_oe after last high");
		check_equal(wdata_out, {d[63:32], new_lo}, "phrase after the register change");
	endtask

	initial begin
		sys_clk = 1'b0;
		rst = 1'b1;
		data_ena = 1'b0;
		wb_req = '0;
		lcg_state = 32'd29;
		repeat (16) @(posedge sys_clk);
		#2;
		rst = 1'b0;
		reset_readback();
		logic_function();
		source_alignment();
		pattern_compare();
		select_inhibit();
		enable_timing();
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
hw/blit_data_pkg.sv
hw/blit_bus_pkg.sv
hw/blit_regs.sv
hw/src_shift.sv
hw/data_comp.sv
hw/data_out.sv
hw/blit_data_path.sv
verif/tb_blit_data_path.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and pass only when the pass line shows up in the output
verilator --binary --timing --assert -f flist.f --top-module tb_blit_data_path \
	&& ./obj_dir/Vtb_blit_data_path | tee /dev/stderr | grep -q "Finished with no errors" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
